// ==== vlog.f ====
+incdir+logic
logic/mem_addr_pkg.sv
logic/mem_cmd_pkg.sv
logic/cmd_decode.sv
logic/bank_sram.sv
logic/read_path.sv
logic/mem_1rw_top.sv
dv/mem_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the memory testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module mem_tb -o mem_tb_sim \
  && ./obj_dir/mem_tb_sim | tee /dev/stderr | grep -q "^TEST PASSED$" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== dv/mem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_cfg.svh"

module mem_tb;

  logic                 clk;
  logic                 rst;
  logic                 rw_read;
  logic                 rw_write;
  mem_addr_pkg::addr_t  rw_addr;
  mem_cmd_pkg::word_t   rw_bw;
  mem_cmd_pkg::word_t   rw_din;
  logic                 flopout_en;
  logic                 rw_vld;
  mem_cmd_pkg::word_t   rw_dout;

  logic [15:0]          lfsr;
  int                   cyc;
  int                   vld_errs;
  int                   data_errs;

  mem_cmd_pkg::word_t   model_mem   [`MEM_NUMADDR];
  mem_cmd_pkg::word_t   model_known [`MEM_NUMADDR];  // Bits written at least once

  mem_cmd_pkg::word_t   exp_data[$];
  mem_cmd_pkg::word_t   exp_mask[$];
  int                   exp_due[$];   // Cycle in which rw_vld must be high
  time                  exp_time[$];

  mem_1rw_top i_dut (
    .clk        (clk),
    .rst        (rst),
    .rw_read    (rw_read),
    .rw_write   (rw_write),
    .rw_addr    (rw_addr),
    .rw_bw      (rw_bw),
    .rw_din     (rw_din),
    .flopout_en (flopout_en),
    .rw_vld     (rw_vld),
    .rw_dout    (rw_dout)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    if (rst) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic rand_bits(input int n, output logic [15:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      val  = {val[14:0], lfsr[0]};
    end
  endtask

  task automatic rand_word(output mem_cmd_pkg::word_t w);
    logic [15:0] v;
    rand_bits(`MEM_WIDTH, v);
    w = v[`MEM_WIDTH-1:0];
  endtask

  // Random row inside the given bank
  task automatic pick_addr(input int bank, output mem_addr_pkg::addr_t a);
    logic [15:0] v;
    rand_bits(`MEM_BITVROW, v);
    a = mem_addr_pkg::addr_t'(int'(v[`MEM_BITVROW-1:0]) * `MEM_NUMVBNK + bank);
  endtask

  task automatic report_value(input string name, input logic [7:0] expected,
                              input logic [7:0] actual, input time issued);
    $display("[FAIL] %0t %s expected %h actual %h (read issued at %0t)",
             $time, name, expected, actual, issued);
  endtask

  // Drives one command and updates the reference model at the same time
  task automatic issue_cmd(input logic rd, input logic wr, input mem_addr_pkg::addr_t addr,
                           input mem_cmd_pkg::word_t bw, input mem_cmd_pkg::word_t din);
    int due;
    @(posedge clk);
    #1;
    rw_read  = rd;
    rw_write = wr;
    rw_addr  = addr;
    rw_bw    = bw;
    rw_din   = din;
    if (addr < `MEM_NUMADDR) begin
      if (wr) begin
        model_mem[addr]   = (model_mem[addr] & ~bw) | (din & bw);
        model_known[addr] = model_known[addr] | bw;
      end else if (rd) begin
        due = cyc + 1;
        if (flopout_en) begin
          due = due + 1;  // Extra output flop
        end
        exp_data.push_back(model_mem[addr]);
        exp_mask.push_back(model_known[addr]);
        exp_due.push_back(due);
        exp_time.push_back($time);
      end
    end
  endtask

  task automatic write_word(input mem_addr_pkg::addr_t addr, input mem_cmd_pkg::word_t bw,
                            input mem_cmd_pkg::word_t din);
    issue_cmd(1'b0, 1'b1, addr, bw, din);
  endtask

  task automatic read_word(input mem_addr_pkg::addr_t addr);
    issue_cmd(1'b1, 1'b0, addr, '0, '0);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) issue_cmd(1'b0, 1'b0, '0, '0, '0);
  endtask

  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while (exp_due.size() != 0 && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (exp_due.size() != 0) begin
      $display("Timeout: %0d reads still waiting for rw_vld", exp_due.size());
      $display("TEST FAILED");
      $finish;
    end
  endtask

  // Output flop must also be empty before the mux moves
  task automatic set_flopout(input logic m);
    wait_drain(20);
    idle_cycles(3);
    flopout_en = m;
  endtask

  task automatic full_word_checks();
    mem_addr_pkg::addr_t a;
    mem_cmd_pkg::word_t  d;
    for (int b = 0; b < `MEM_NUMVBNK; b++) begin
      pick_addr(b, a);
      rand_word(d);
      write_word(a, 8'hff, d);
      read_word(a);  // Back to back with the write
    end
    rand_word(d);
    write_word(mem_addr_pkg::addr_t'(`MEM_NUMADDR - 1), 8'hff, d);
    read_word(mem_addr_pkg::addr_t'(`MEM_NUMADDR - 1));
    idle_cycles(1);
    wait_drain(10);
  endtask

  task automatic partial_write_checks();
    mem_addr_pkg::addr_t a;
    mem_cmd_pkg::word_t  d;
    mem_cmd_pkg::word_t  bw;
    for (int i = 0; i < 6; i++) begin
      pick_addr(i % `MEM_NUMVBNK, a);
      rand_word(d);
      write_word(a, 8'hff, d);
      rand_word(bw);
      rand_word(d);
      write_word(a, bw, d);
      read_word(a);
    end
    // Possibly never written so only known bits are compared
    pick_addr(2, a);
    rand_word(bw);
    rand_word(d);
    write_word(a, bw, d);
    read_word(a);
    idle_cycles(1);
    wait_drain(10);
  endtask

  task automatic burst_reads(input int n);
    mem_addr_pkg::addr_t a;
    logic [15:0]         v;
    for (int i = 0; i < n; i++) begin
      rand_bits(2, v);
      pick_addr(int'(v[1:0]) % `MEM_NUMVBNK, a);
      read_word(a);
    end
    idle_cycles(1);
    wait_drain(n + 10);
  endtask

  task automatic collision_and_range_checks();
    mem_addr_pkg::addr_t a;
    mem_addr_pkg::addr_t oa;
    mem_addr_pkg::addr_t wa;
    mem_cmd_pkg::word_t  d;
    logic [15:0]         v;
    pick_addr(1, a);
    rand_word(d);
    write_word(a, 8'hff, ~d);
    issue_cmd(1'b1, 1'b1, a, 8'hff, d);  // Write wins and the read is dropped
    read_word(a);
    rand_bits(4, v);
    oa = mem_addr_pkg::addr_t'(`MEM_NUMADDR + int'(v[3:0]));
    wa = mem_addr_pkg::addr_t'(int'(oa) - `MEM_NUMADDR);  // Row would wrap onto this word
    rand_word(d);
    write_word(wa, 8'hff, d);
    write_word(oa, 8'hff, ~d);
    read_word(wa);
    read_word(oa);
    idle_cycles(1);
    wait_drain(10);
  endtask

  // Sampled mid cycle away from the edge where outputs move
  always @(negedge clk) begin
    if (!rst) begin
      if (exp_due.size() != 0 && exp_due[0] == cyc) begin
        assert (rw_vld === 1'b1) else begin
          vld_errs++;
          report_value("rw_vld", 8'h01, {7'b0, rw_vld}, exp_time[0]);
        end
        assert (((rw_dout ^ exp_data[0]) & exp_mask[0]) == '0) else begin
          data_errs++;
          report_value("rw_dout", exp_data[0], rw_dout, exp_time[0]);
        end
        void'(exp_data.pop_front());
        void'(exp_mask.pop_front());
        void'(exp_due.pop_front());
        void'(exp_time.pop_front());
      end else begin
        assert (rw_vld === 1'b0) else begin
          vld_errs++;
          report_value("rw_vld", 8'h00, {7'b0, rw_vld}, $time);
        end
      end
    end
  end

  initial begin
    rst        = 1'b1;
    rw_read    = 1'b0;
    rw_write   = 1'b0;
    rw_addr    = '0;
    rw_bw      = '0;
    rw_din     = '0;
    flopout_en = 1'b0;
    lfsr       = 16'd16786;
    vld_errs   = 0;
    data_errs  = 0;
    for (int i = 0; i < `MEM_NUMADDR; i++) begin
      model_mem[i]   = '0;
      model_known[i] = '0;
    end
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    idle_cycles(5);  // rw_vld must stay low here
    for (int mode = 0; mode < 2; mode++) begin
      set_flopout(mode[0]);
      full_word_checks();
      partial_write_checks();
      burst_reads(12);
      collision_and_range_checks();
    end
    idle_cycles(4);
    wait_drain(20);
    $display("Errors: rw_vld %0d, rw_dout %0d", vld_errs, data_errs);
    if (vld_errs == 0 && data_errs == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/mem_1rw_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_cfg.svh"

module mem_1rw_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 rw_read,
  input  logic                 rw_write,
  input  mem_addr_pkg::addr_t  rw_addr,
  input  mem_cmd_pkg::word_t   rw_bw,
  input  mem_cmd_pkg::word_t   rw_din,
  input  logic                 flopout_en,
  output logic                 rw_vld,
  output mem_cmd_pkg::word_t   rw_dout
);

  logic [`MEM_NUMVBNK-1:0]                  bank_read;
  logic [`MEM_NUMVBNK-1:0]                  bank_write;
  mem_addr_pkg::row_t                       bank_row;
  mem_cmd_pkg::word_t                       bank_bw;
  mem_cmd_pkg::word_t                       bank_din;
  mem_cmd_pkg::word_t [`MEM_NUMVBNK-1:0]    bank_dout;
  logic                                     rd_issue;
  mem_addr_pkg::bank_t                      rd_bank;

  cmd_decode i_decode (
    .rw_read    (rw_read),
    .rw_write   (rw_write),
    .rw_addr    (rw_addr),
    .rw_bw      (rw_bw),
    .rw_din     (rw_din),
    .bank_read  (bank_read),
    .bank_write (bank_write),
    .bank_row   (bank_row),
    .bank_bw    (bank_bw),
    .bank_din   (bank_din),
    .rd_issue   (rd_issue),
    .rd_bank    (rd_bank)
  );

  // One physical SRAM per virtual bank
  for (genvar b = 0; b < `MEM_NUMVBNK; b++) begin : g_bank
    bank_sram i_bank (
      .clk   (clk),
      .read  (bank_read[b]),
      .write (bank_write[b]),
      .row   (bank_row),
      .bw    (bank_bw),
      .din   (bank_din),
      .dout  (bank_dout[b])
    );
  end

  read_path i_read_path (
    .clk        (clk),
    .rst        (rst),
    .flopout_en (flopout_en),
    .rd_issue   (rd_issue),
    .rd_bank    (rd_bank),
    .bank_dout  (bank_dout),
    .rw_vld     (rw_vld),
    .rw_dout    (rw_dout)
  );

endmodule

`default_nettype wire

// ==== logic/read_path.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_cfg.svh"

module read_path (
  input  logic                                          clk,
  input  logic                                          rst,
  input  logic                                          flopout_en,
  input  logic                                          rd_issue,
  input  mem_addr_pkg::bank_t                           rd_bank,
  input  mem_cmd_pkg::word_t [`MEM_NUMVBNK-1:0]         bank_dout,
  output logic                                          rw_vld,
  output mem_cmd_pkg::word_t                            rw_dout
);

  logic                 vld_s1;
  mem_addr_pkg::bank_t  bank_s1;
  mem_cmd_pkg::word_t   dout_s1;
  logic                 vld_s2;
  mem_cmd_pkg::word_t   dout_s2;

  // Stage 1 lines up with the SRAM output register
  always_ff @(posedge clk) begin
    if (rst) begin
      vld_s1 <= 1'b0;
    end else begin
      vld_s1 <= rd_issue;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_issue) begin
      bank_s1 <= rd_bank;
    end
  end

  always_comb begin
    dout_s1 = '0;
    for (int b = 0; b < `MEM_NUMVBNK; b++) begin
      if (bank_s1 == mem_addr_pkg::bank_t'(b)) begin
        dout_s1 = bank_dout[b];
      end
    end
  end

  // Stage 2 is the optional output flop
  always_ff @(posedge clk) begin
    if (rst) begin
      vld_s2  <= 1'b0;
      dout_s2 <= '0;
    end else begin
      vld_s2  <= vld_s1;
      dout_s2 <= dout_s1;
    end
  end

  // Level is static while reads are in flight
  assign rw_vld  = flopout_en ? vld_s2  : vld_s1;
  assign rw_dout = flopout_en ? dout_s2 : dout_s1;

endmodule

`default_nettype wire

// ==== logic/bank_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_cfg.svh"

module bank_sram (
  input  logic                clk,
  input  logic                read,
  input  logic                write,
  input  mem_addr_pkg::row_t  row,
  input  mem_cmd_pkg::word_t  bw,
  input  mem_cmd_pkg::word_t  din,
  output mem_cmd_pkg::word_t  dout
);

  mem_cmd_pkg::word_t mem [`MEM_NUMVROW];

  // Per-bit write, disabled bits keep their old contents
  always_ff @(posedge clk) begin
    if (write) begin
      for (int i = 0; i < `MEM_WIDTH; i++) begin
        if (bw[i]) begin
          mem[row][i] <= din[i];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (read) begin
      dout <= mem[row];  // Holds until the next read
    end
  end

endmodule

`default_nettype wire

// ==== logic/cmd_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_cfg.svh"

module cmd_decode (
  input  logic                       rw_read,
  input  logic                       rw_write,
  input  mem_addr_pkg::addr_t        rw_addr,
  input  mem_cmd_pkg::word_t         rw_bw,
  input  mem_cmd_pkg::word_t         rw_din,
  output logic [`MEM_NUMVBNK-1:0]    bank_read,
  output logic [`MEM_NUMVBNK-1:0]    bank_write,
  output mem_addr_pkg::row_t         bank_row,
  output mem_cmd_pkg::word_t         bank_bw,
  output mem_cmd_pkg::word_t         bank_din,
  output logic                       rd_issue,
  output mem_addr_pkg::bank_t        rd_bank
);

  logic                in_range;
  mem_cmd_pkg::op_e    op;
  mem_addr_pkg::bank_t addr_bank;
  mem_addr_pkg::row_t  addr_row;

  assign in_range = (rw_addr < `MEM_NUMADDR);

  // Write wins over read and out of range is no command at all
  always_comb begin
    op = mem_cmd_pkg::op_idle;
    if (in_range) begin
      if (rw_write) begin
        op = mem_cmd_pkg::op_write;
      end else if (rw_read) begin
        op = mem_cmd_pkg::op_read;
      end
    end
  end

  // Non power of two mapping puts consecutive words in different banks
  assign addr_bank = mem_addr_pkg::bank_t'(rw_addr % `MEM_NUMVBNK);
  assign addr_row  = mem_addr_pkg::row_t'(rw_addr / `MEM_NUMVBNK);

  always_comb begin
    bank_read  = '0;
    bank_write = '0;
    for (int b = 0; b < `MEM_NUMVBNK; b++) begin
      if (addr_bank == mem_addr_pkg::bank_t'(b)) begin
        bank_read[b]  = (op == mem_cmd_pkg::op_read);
        bank_write[b] = (op == mem_cmd_pkg::op_write);
      end
    end
  end

  // Shared by all banks while only the strobed one acts
  assign bank_row = addr_row;
  assign bank_bw  = rw_bw;
  assign bank_din = rw_din;

  assign rd_issue = (op == mem_cmd_pkg::op_read);
  assign rd_bank  = addr_bank;  // Meaningful only with rd_issue

endmodule

`default_nettype wire

// ==== logic/mem_cmd_pkg.sv ====
`default_nettype none

`include "mem_cfg.svh"

package mem_cmd_pkg;

  // Command class after strobe priority and range check
  typedef enum logic [1:0] {
    op_idle  = 2'd0,
    op_read  = 2'd1,
    op_write = 2'd2
  } op_e;

  typedef logic [`MEM_WIDTH-1:0] word_t;  // Data or bit enables

endpackage

`default_nettype wire

// ==== logic/mem_addr_pkg.sv ====
`default_nettype none

`include "mem_cfg.svh"

package mem_addr_pkg;

  // Full logical address as seen at the top level ports
  typedef logic [`MEM_BITADDR-1:0] addr_t;

  typedef logic [`MEM_BITVBNK-1:0] bank_t;  // Which virtual bank

  typedef logic [`MEM_BITVROW-1:0] row_t;   // Row inside one bank

endpackage

`default_nettype wire

// ==== logic/mem_cfg.svh ====
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// Logical memory shape
`define MEM_WIDTH    8    // Bits per data word
`define MEM_NUMADDR  48   // Logical word count that is not a power of two
`define MEM_BITADDR  6    // Logical address width

// Virtual banking
`define MEM_NUMVBNK  3    // Bank = addr % 3
`define MEM_BITVBNK  2
`define MEM_NUMVROW  16   // Row = addr / 3
`define MEM_BITVROW  4

`endif
